/* rtl/noc_pkg.sv */
package noc_pkg;

  localparam int NUM_INPUTS  = 3;                                      // Inputs sharing this output.
  localparam int NUM_VCS     = 2;                                      // Virtual channels on the link.
  localparam int FLIT_DATA_W = 32;                                     // Payload width in bits.
  localparam int VC_ID_W     = (NUM_VCS > 1) ? $clog2(NUM_VCS) : 1;   // Width of a channel number.
  localparam int FLIT_W      = 2 + VC_ID_W + FLIT_DATA_W;              // Head, tail, channel, payload.
  localparam int HEAD_BIT    = FLIT_W - 1;
  localparam int TAIL_BIT    = FLIT_W - 2;

  typedef logic [VC_ID_W-1:0]     vc_id_t;
  typedef logic [NUM_VCS-1:0]     vc_mask_t;     // One bit per virtual channel.
  typedef logic [FLIT_DATA_W-1:0] flit_data_t;
  typedef logic [FLIT_W-1:0]      flit_t;
  typedef logic [NUM_INPUTS-1:0]  input_sel_t;   // One-hot input select.

  typedef enum logic {
    ARB_IDLE,                                    // Waiting for an eligible head flit.
    ARB_LOCKED                                   // A packet owns the output until its tail.
  } arb_state_t;

  function automatic logic flit_is_head(flit_t flit);
    return flit[HEAD_BIT];
  endfunction

  function automatic logic flit_is_tail(flit_t flit);
    return flit[TAIL_BIT];
  endfunction

  function automatic vc_id_t flit_vc(flit_t flit);
    return flit[FLIT_DATA_W+:VC_ID_W];
  endfunction

  function automatic flit_data_t flit_payload(flit_t flit);
    return flit[FLIT_DATA_W-1:0];
  endfunction

  // Valid mask with only the bit of the flit's own channel set.
  function automatic vc_mask_t flit_vc_mask(flit_t flit);
    return vc_mask_t'(1) << flit_vc(flit);
  endfunction

endpackage

/* rtl/flit_if.sv */
`timescale 1ns/100ps

interface flit_if;
  import noc_pkg::*;

  vc_mask_t valid;         // At most one bit high, the channel of the flit.
  flit_t    flit;
  vc_mask_t ready;         // A flit moves when valid and ready meet at a rising edge.
  vc_mask_t vc_available;  // Downstream channel may start a new packet.

  modport initiator (
    output valid,
    output flit,
    input  ready,
    input  vc_available
  );

  modport target (
    input  valid,
    input  flit,
    output ready,
    output vc_available
  );

endinterface

/* rtl/flit_input_buffer.sv */
`timescale 1ns/100ps

module flit_input_buffer (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  noc_pkg::vc_mask_t i_valid,
  input  noc_pkg::flit_t    i_flit,
  output noc_pkg::vc_mask_t o_ready,
  flit_if.initiator        flit_out_if
);
  import noc_pkg::*;

  flit_t       mem [2];      // Two flit entries.
  logic        wr_ptr_q;
  logic        rd_ptr_q;
  logic [1:0]  count_q;      // Holds 0, 1 or 2.
  logic        push;
  logic        pop;
  flit_t       head_flit;

  assign o_ready   = (count_q < 2'd2) ? '1 : '0;        // Open on every channel until full.
  assign push      = |(i_valid & o_ready);
  assign pop       = |(flit_out_if.valid & flit_out_if.ready);
  assign head_flit = mem[rd_ptr_q];                     // Oldest entry is always offered.

  assign flit_out_if.flit  = head_flit;
  assign flit_out_if.valid = (count_q != 2'd0) ? flit_vc_mask(head_flit) : '0;

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr_q] <= i_flit;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;                          // Pointers wrap over two entries.
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;                    // Both or neither leave it unchanged.
      endcase
    end
  end

endmodule

/* rtl/flit_arbiter.sv */
`timescale 1ns/100ps

module flit_arbiter (
  input  logic                                       i_clk,
  input  logic                                       i_rst_n,
  input  logic [noc_pkg::NUM_INPUTS-1:0]             i_head_valid,
  input  noc_pkg::flit_t [noc_pkg::NUM_INPUTS-1:0]   i_head_flit,
  input  noc_pkg::vc_mask_t                          i_out_vc_available,
  input  logic                                       i_xfer,
  output noc_pkg::input_sel_t                        o_select
);
  import noc_pkg::*;

  arb_state_t  state_q;
  input_sel_t  select_q;
  input_sel_t  last_q;       // One-hot marker of the last granted input.
  input_sel_t  eligible;
  input_sel_t  grant;
  flit_t       sel_flit;

  assign o_select = select_q;

  // A head flit is eligible only if its channel downstream can take a new packet.
  always_comb begin
    for (int i = 0; i < NUM_INPUTS; i++) begin
      eligible[i] = i_head_valid[i] && flit_is_head(i_head_flit[i]) &&
                    i_out_vc_available[flit_vc(i_head_flit[i])];
    end
  end

  always_comb begin
    int last_idx;
    int idx;
    last_idx = 0;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      if (last_q[i]) begin
        last_idx = i;
      end
    end
    grant = '0;
    for (int k = 1; k <= NUM_INPUTS; k++) begin   // Search starts just after the last winner.
      idx = (last_idx + k) % NUM_INPUTS;
      if (eligible[idx] && (grant == '0)) begin
        grant[idx] = 1'b1;
      end
    end
  end

  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      sel_flit = sel_flit | (i_head_flit[i] & {FLIT_W{select_q[i]}});
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q  <= ARB_IDLE;
      select_q <= '0;
      last_q   <= input_sel_t'(1) << (NUM_INPUTS - 1);  // Input 0 wins the first round.
    end else begin
      case (state_q)
        ARB_IDLE: if (|grant) begin
          state_q  <= ARB_LOCKED;
          select_q <= grant;
          last_q   <= grant;
        end
        ARB_LOCKED: if (i_xfer && flit_is_tail(sel_flit)) begin
          state_q  <= ARB_IDLE;                         // Released by the tail transfer.
          select_q <= '0;
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

endmodule

/* rtl/flit_if_mux.sv */
`timescale 1ns/100ps

module flit_if_mux (
  input  noc_pkg::input_sel_t i_select,
  flit_if.target              flit_in_if [noc_pkg::NUM_INPUTS],
  flit_if.initiator           flit_out_if
);
  import noc_pkg::*;

  vc_mask_t  valid_in [NUM_INPUTS];
  flit_t     flit_in [NUM_INPUTS];
  vc_mask_t  valid_out;
  flit_t     flit_out;

  for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_port
    assign valid_in[i] = flit_in_if[i].valid;
    assign flit_in[i]  = flit_in_if[i].flit;

    // Only the selected input sees the downstream handshake.
    assign flit_in_if[i].ready        = i_select[i] ? flit_out_if.ready : '0;
    assign flit_in_if[i].vc_available = i_select[i] ? flit_out_if.vc_available : '0;
  end

  always_comb begin
    valid_out = '0;
    flit_out  = '0;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      valid_out = valid_out | (valid_in[i] & {NUM_VCS{i_select[i]}});  // One-hot AND-OR.
      flit_out  = flit_out | (flit_in[i] & {FLIT_W{i_select[i]}});
    end
  end

  assign flit_out_if.valid = valid_out;
  assign flit_out_if.flit  = flit_out;

endmodule

/* rtl/flit_output_slice.sv */
`timescale 1ns/100ps

module flit_output_slice (
  input  logic             i_clk,
  input  logic             i_rst_n,
  flit_if.target           flit_in_if,
  output noc_pkg::vc_mask_t o_out_valid,
  output noc_pkg::flit_t    o_out_flit,
  input  noc_pkg::vc_mask_t i_out_ready,
  input  noc_pkg::vc_mask_t i_out_vc_available,
  output logic             o_in_xfer
);
  import noc_pkg::*;

  logic   full_q;
  flit_t  flit_q;
  logic   leaving;
  logic   accept;

  assign o_out_valid = full_q ? flit_vc_mask(flit_q) : '0;
  assign o_out_flit  = flit_q;
  assign leaving     = |(o_out_valid & i_out_ready);     // Held flit moves on at this edge.

  // Room for a new flit when empty or when the held one is leaving.
  assign flit_in_if.ready        = (!full_q || leaving) ? '1 : '0;
  assign flit_in_if.vc_available = i_out_vc_available;

  assign accept    = |(flit_in_if.valid & flit_in_if.ready);
  assign o_in_xfer = accept;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      flit_q <= flit_in_if.flit;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (leaving) begin
      full_q <= 1'b0;
    end
  end

endmodule

/* rtl/noc_output_switch.sv */
`timescale 1ns/100ps

module noc_output_switch (
  input  logic                                        i_clk,
  input  logic                                        i_rst_n,
  input  noc_pkg::vc_mask_t [noc_pkg::NUM_INPUTS-1:0] i_in_valid,
  input  noc_pkg::flit_t [noc_pkg::NUM_INPUTS-1:0]    i_in_flit,
  output noc_pkg::vc_mask_t [noc_pkg::NUM_INPUTS-1:0] o_in_ready,
  output noc_pkg::vc_mask_t                           o_out_valid,
  output noc_pkg::flit_t                              o_out_flit,
  input  noc_pkg::vc_mask_t                           i_out_ready,
  input  noc_pkg::vc_mask_t                           i_out_vc_available
);
  import noc_pkg::*;

  flit_if in_if [NUM_INPUTS] ();
  flit_if out_if ();

  logic [NUM_INPUTS-1:0]   head_valid;
  flit_t [NUM_INPUTS-1:0]  head_flit;
  input_sel_t              select;
  logic                    xfer;

  for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_input
    flit_input_buffer u_buffer (
      .i_clk       (i_clk        ),
      .i_rst_n     (i_rst_n      ),
      .i_valid     (i_in_valid[i]),
      .i_flit      (i_in_flit[i] ),
      .o_ready     (o_in_ready[i]),
      .flit_out_if (in_if[i]     )
    );

    assign head_valid[i] = |in_if[i].valid;   // The arbiter sees every buffer head.
    assign head_flit[i]  = in_if[i].flit;
  end

  flit_arbiter u_arbiter (
    .i_clk              (i_clk                ),
    .i_rst_n            (i_rst_n              ),
    .i_head_valid       (head_valid           ),
    .i_head_flit        (head_flit            ),
    .i_out_vc_available (out_if.vc_available  ),
    .i_xfer             (xfer                 ),
    .o_select           (select               )
  );

  flit_if_mux u_mux (
    .i_select    (select),
    .flit_in_if  (in_if ),
    .flit_out_if (out_if)
  );

  flit_output_slice u_slice (
    .i_clk              (i_clk             ),
    .i_rst_n            (i_rst_n           ),
    .flit_in_if         (out_if            ),
    .o_out_valid        (o_out_valid       ),
    .o_out_flit         (o_out_flit        ),
    .i_out_ready        (i_out_ready       ),
    .i_out_vc_available (i_out_vc_available),
    .o_in_xfer          (xfer              )
  );

endmodule

/* verification/tb_noc_output_switch.sv */
`timescale 1ns/100ps

module tb_noc_output_switch;
  import noc_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_ROWS       = 18;

  typedef struct {
    int         phase;
    int         inp;
    int         vc;
    int         len;
    flit_data_t base;
  } pkt_row_t;

  // Columns are phase, input, channel, length and payload base.
  pkt_row_t pkt_rows [NUM_ROWS] = '{
    '{0, 0, 0, 3, 32'h0100}, '{0, 1, 0, 3, 32'h0200}, '{0, 2, 0, 3, 32'h0300},
    '{0, 0, 0, 3, 32'h0110}, '{0, 1, 0, 3, 32'h0210}, '{0, 2, 0, 3, 32'h0310},
    '{1, 0, 1, 2, 32'h0400}, '{1, 0, 1, 2, 32'h0410}, '{1, 1, 0, 4, 32'h0500},
    '{1, 2, 1, 1, 32'h0600}, '{2, 0, 0, 5, 32'h0700}, '{2, 0, 1, 1, 32'h0710},
    '{2, 1, 1, 3, 32'h0800}, '{2, 1, 0, 2, 32'h0810}, '{2, 2, 0, 1, 32'h0900},
    '{2, 2, 1, 4, 32'h0910}, '{2, 0, 1, 2, 32'h0720}, '{2, 1, 0, 3, 32'h0820}
  };

  logic                      i_clk;
  logic                      i_rst_n;
  vc_mask_t [NUM_INPUTS-1:0] i_in_valid;
  flit_t [NUM_INPUTS-1:0]    i_in_flit;
  vc_mask_t [NUM_INPUTS-1:0] o_in_ready;
  vc_mask_t                  o_out_valid;
  flit_t                     o_out_flit;
  vc_mask_t                  i_out_ready;
  vc_mask_t                  i_out_vc_available;

  flit_t    exp_q [NUM_INPUTS][$];   // Flits accepted by each input, in order.
  int       seed       = 61;
  int       cur_phase  = 0;
  int       done_cnt   = 0;
  int       owner      = -1;         // Input whose packet holds the output.
  int       fair_last  = -1;
  int       flit_errs  = 0;
  int       vc_errs    = 0;
  int       proto_errs = 0;
  logic     timed_out  = 1'b0;
  logic     rand_mode  = 1'b0;
  logic     gate_vc1   = 1'b0;
  logic     fair_check = 1'b0;
  logic     in_packet  = 1'b0;
  logic     held       = 1'b0;
  flit_t    held_flit;
  vc_mask_t held_valid;

  noc_output_switch i_dut (.*);

  always #5 i_clk = ~i_clk;

  always @(negedge i_clk) begin
    if (rand_mode) begin
      i_out_ready        = vc_mask_t'($random(seed));
      i_out_vc_available = vc_mask_t'($random(seed));
    end
  end

  task automatic check_flit(string name, flit_t expected, flit_t actual);
    if (expected !== actual) begin
      flit_errs++;
      $display("FAIL %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_vc(string name, vc_mask_t expected, vc_mask_t actual);
    if (expected !== actual) begin
      vc_errs++;
      $display("FAIL %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic send_input(int idx);
    flit_t f;
    int    wait_cnt;
    logic  accepted;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (pkt_rows[r].phase == cur_phase && pkt_rows[r].inp == idx) begin
        for (int k = 0; k < pkt_rows[r].len && !timed_out; k++) begin
          f = {(k == 0), (k == pkt_rows[r].len - 1), vc_id_t'(pkt_rows[r].vc),
               pkt_rows[r].base + flit_data_t'(k)};
          i_in_flit[idx]  = f;
          i_in_valid[idx] = vc_mask_t'(1) << pkt_rows[r].vc;
          accepted = 1'b0;
          wait_cnt = 0;
          while (!accepted && wait_cnt < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            accepted = o_in_ready[idx][pkt_rows[r].vc];
            wait_cnt++;
          end
          if (accepted) begin
            exp_q[idx].push_back(f);
          end else begin
            $display("Timeout: input %0d was never ready for flit %h", idx, f);
            timed_out = 1'b1;
          end
          @(negedge i_clk);
          i_in_valid[idx] = '0;
        end
      end
    end
    done_cnt++;
  endtask

  task automatic handle_output(flit_t f, vc_mask_t v);
    int    src;
    flit_t exp_flit;
    src = owner;
    if (f[FLIT_W-1]) begin                          // A head flit claims a new source.
      if (in_packet) begin
        proto_errs++;
        $display("Head flit %h arrived before the tail from input %0d", f, owner);
      end
      src = -1;
      for (int i = 0; i < NUM_INPUTS; i++) begin
        if (exp_q[i].size() > 0 && exp_q[i][0] == f) begin
          src = i;
        end
      end
      if (fair_check && fair_last >= 0 && src != (fair_last + 1) % NUM_INPUTS) begin
        proto_errs++;
        $display("Input %0d won after input %0d, out of rotating order", src, fair_last);
      end
      fair_last = src;
      owner     = src;
      in_packet = (src >= 0);
    end
    if (!in_packet) begin
      proto_errs++;
      $display("Flit %h does not belong to any expected packet", f);
    end else begin
      exp_flit = exp_q[src].pop_front();
      check_flit("o_out_flit", exp_flit, f);
      check_vc("o_out_valid", vc_mask_t'(1) << exp_flit[FLIT_DATA_W+:VC_ID_W], v);
      in_packet = !exp_flit[FLIT_W-2];              // The tail ends the packet.
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (!timed_out && (done_cnt < NUM_INPUTS ||
           exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)) begin
      @(posedge i_clk);
      cnt++;
      if (cnt >= TIMEOUT_CYCLES) begin
        $display("Timeout: phase %0d did not deliver all of its flits", cur_phase);
        timed_out = 1'b1;
      end
    end
  endtask

  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if (held) begin                               // A stalled flit must hold still.
        check_flit("o_out_flit", held_flit, o_out_flit);
        check_vc("o_out_valid", held_valid, o_out_valid);
      end
      if (gate_vc1 && o_out_valid[1]) begin
        proto_errs++;
        $display("Flit %h left on channel 1 while that channel was unavailable", o_out_flit);
      end
      if (|(o_out_valid & i_out_ready)) begin
        handle_output(o_out_flit, o_out_valid);
      end
      held       = |o_out_valid && !(|(o_out_valid & i_out_ready));
      held_flit  = o_out_flit;
      held_valid = o_out_valid;
    end
  end

  initial begin
    i_clk              = 1'b0;
    i_rst_n            = 1'b0;
    i_in_valid         = '0;
    i_in_flit          = '0;
    i_out_ready        = '1;
    i_out_vc_available = '1;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_vc("o_out_valid", '0, o_out_valid);
    for (int i = 0; i < NUM_INPUTS; i++) begin
      check_vc("o_in_ready", '1, o_in_ready[i]);
    end
    for (int ph = 0; ph < 3 && !timed_out; ph++) begin
      cur_phase  = ph;
      done_cnt   = 0;
      fair_check = (ph == 0);
      fair_last  = -1;
      gate_vc1   = (ph == 1);
      rand_mode  = (ph == 2);
      if (ph == 1) begin
        i_out_vc_available = 2'b01;                 // Channel 1 may not start packets.
      end
      fork
        send_input(0);
        send_input(1);
        send_input(2);
      join_none
      if (ph == 1) begin
        repeat (40) @(negedge i_clk);               // Channel 0 traffic drains meanwhile.
        gate_vc1           = 1'b0;
        i_out_vc_available = '1;
      end
      wait_drain();
      rand_mode = 1'b0;
      @(negedge i_clk);
      i_out_ready        = '1;
      i_out_vc_available = '1;
    end
    $display("Errors: flit %0d, channel %0d, protocol %0d, timeout %0d",
             flit_errs, vc_errs, proto_errs, timed_out);
    if (flit_errs + vc_errs + proto_errs == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/noc_pkg.sv
rtl/flit_if.sv
rtl/flit_input_buffer.sv
rtl/flit_arbiter.sv
rtl/flit_if_mux.sv
rtl/flit_output_slice.sv
rtl/noc_output_switch.sv
verification/tb_noc_output_switch.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_noc_output_switch -o tb_sim
out=$(./obj_dir/tb_sim)
echo "$out"
if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
